//--- dv/ipv4_fwd_model.svh
// reference model for the testbench
// ones' complement checksum, first-match route model, expected result, xorshift
`ifndef IPV4_FWD_MODEL_SVH
`define IPV4_FWD_MODEL_SVH

// model copy of the route table, kept in step with the wishbone writes
logic        model_valid  [ROUTE_ENTRIES];
logic [31:0] model_prefix [ROUTE_ENTRIES];
logic [5:0]  model_len    [ROUTE_ENTRIES];
port_t       model_port   [ROUTE_ENTRIES];

// ones' complement sum of the ten halfwords, carries folded back in
function automatic logic [15:0] ones_sum(input ipv4_hdr_t hdr);
    logic [159:0] bits;
    logic [31:0]  acc;
    bits = hdr;
    acc = 32'd0;
    for (int i = 0; i < 10; i++) begin
        acc = acc + {16'd0, bits[i*16 +: 16]};
    end
    while (acc[31:16] != 16'd0) begin
        acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
    end
    return acc[15:0];
endfunction

// full recomputation of the checksum field
function automatic ipv4_hdr_t with_checksum(input ipv4_hdr_t hdr);
    ipv4_hdr_t h;
    h = hdr;
    h.hdr_checksum = 16'h0000;
    h.hdr_checksum = ~ones_sum(h);
    return h;
endfunction

// {hit, port} of the lowest index entry whose top prefix bits match
function automatic logic [4:0] route_match(input logic [31:0] addr);
    logic       match;
    logic [4:0] res;
    res = 5'd0;
    for (int i = ROUTE_ENTRIES - 1; i >= 0; i--) begin
        match = model_valid[i];
        for (int b = 0; b < 32; b++) begin
            if (b < int'(model_len[i]) && addr[31-b] != model_prefix[i][31-b]) begin
                match = 1'b0;
            end
        end
        if (match) begin
            res = {1'b1, model_port[i]};
        end
    end
    return res;
endfunction

// what the pipe must deliver for one input header
function automatic fwd_result_t expect_result(input ipv4_hdr_t hdr);
    fwd_result_t r;
    logic [4:0]  hit;
    r.hdr = hdr;
    r.port = 4'd0;
    hit = route_match(hdr.dst_addr);
    if (hdr.version != 4'd4 || hdr.ihl != 4'd5) begin
        r.verdict = verdict_bad_header;
    end else if (ones_sum(hdr) != 16'hffff) begin
        r.verdict = verdict_bad_checksum;
    end else if (hdr.ttl < 8'd2) begin
        r.verdict = verdict_ttl_expired;
    end else if (!hit[4]) begin
        r.verdict = verdict_no_route;
    end else begin
        r.verdict = verdict_forward;
        r.hdr.ttl = hdr.ttl - 8'd1;
        r.hdr = with_checksum(r.hdr);
        r.port = hit[3:0];
    end
    return r;
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

//--- dv/ipv4_fwd_tb.sv
// testbench for the ipv4 forwarding stage
// route table over wishbone, vector table with random back-pressure, latency check
module ipv4_fwd_tb
    import ipv4_fwd_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROUTE_ENTRIES = 4;
    localparam int NUM_VECTORS   = 11;
    localparam int CYCLE_LIMIT   = NUM_VECTORS * 20 + 200;

    // corruption bits applied to a base header
    localparam logic [3:0] CORR_NONE    = 4'b0000;
    localparam logic [3:0] CORR_VERSION = 4'b0001;
    localparam logic [3:0] CORR_IHL     = 4'b0010;
    localparam logic [3:0] CORR_CSUM    = 4'b0100;
    localparam logic [3:0] CORR_TTL     = 4'b1000;

    typedef struct packed {
        logic [31:0]  dst_addr;
        logic [7:0]   ttl;
        logic [3:0]   corrupt;
        fwd_verdict_e verdict;
        port_t        port;
    } vector_t;

    `include "ipv4_fwd_model.svh"

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    ipv4_hdr_t   in_hdr;
    logic        out_valid;
    logic        out_ready = 1'b0;
    fwd_result_t out_result;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    vector_t      vectors [NUM_VECTORS];
    fwd_result_t  exp_q [$];
    int           stamp_q [$];
    int           cycle = 0;
    logic [31:0]  rng_state = 32'he378;
    logic         rand_ready = 1'b1;
    logic         check_latency = 1'b0;
    fwd_verdict_e last_verdict = verdict_forward;
    int           ack_count = 0;
    int           access_count = 0;
    int           mon_value_errors = 0;
    int           mon_other_errors = 0;
    int           stim_value_errors = 0;
    int           stim_other_errors = 0;

    ipv4_fwd_top #(
        .ROUTE_ENTRIES ( ROUTE_ENTRIES )
    ) ipv4_fwd_top_inst (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .in_valid   ( in_valid   ),
        .in_ready   ( in_ready   ),
        .in_hdr     ( in_hdr     ),
        .out_valid  ( out_valid  ),
        .out_ready  ( out_ready  ),
        .out_result ( out_result ),
        .wb_req     ( wb_req     ),
        .wb_rsp     ( wb_rsp     )
    );

    always #4 clk = ~clk;

    ////////////////////
    // stimulus helpers

    // good base header, then the requested corruption
    function automatic ipv4_hdr_t build_header(input vector_t v, input int idx);
        ipv4_hdr_t h;
        h.version = 4'd4;
        h.ihl = 4'd5;
        h.tos = 8'h00;
        h.total_len = 16'd20;
        h.ident = 16'h1000 + idx[15:0];
        h.flags_frag = 16'h4000;
        h.ttl = v.ttl;
        h.protocol = 8'd17;
        h.hdr_checksum = 16'h0000;
        h.src_addr = 32'hc0a8_0a01;
        h.dst_addr = v.dst_addr;
        if ((v.corrupt & CORR_VERSION) != 4'd0) h.version = 4'd6;
        if ((v.corrupt & CORR_IHL) != 4'd0) h.ihl = 4'd6;
        if ((v.corrupt & CORR_TTL) != 4'd0) h.ttl = 8'd1;
        h = with_checksum(h);
        // flip bits after the sum so only the checksum is wrong
        if ((v.corrupt & CORR_CSUM) != 4'd0) h.hdr_checksum = h.hdr_checksum ^ 16'h0101;
        return h;
    endfunction

    // hold valid until the pipe takes the header
    task automatic send_header(input ipv4_hdr_t hdr);
        in_valid <= 1'b1;
        in_hdr <= hdr;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // let the monitor see the last transfer, then empty the queue
    task automatic wait_drain();
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    // one classic cycle, strobe held until ack
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] dat_w,
                             output logic [31:0] dat_r);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat_w};
        @(posedge clk);
        while (!wb_rsp.ack) @(posedge clk);
        dat_r = wb_rsp.dat_r;
        wb_req <= '0;
        access_count = access_count + 1;
        @(posedge clk);
        if (wb_rsp.ack) begin
            stim_other_errors++;
            $display("wishbone ack held for a second cycle at address %h", adr);
        end
    endtask

    task automatic read_check(input logic [7:0] adr, input logic [31:0] expected);
        logic [31:0] rd;
        wb_access(1'b0, adr, 32'd0, rd);
        if (rd !== expected) begin
            stim_value_errors++;
            $display("FAIL wb_rsp.dat_r at %h: got %h expected %h", adr, rd, expected);
        end
    endtask

    // entry i sits at words 2i and 2i+1
    task automatic program_route(input int idx, input logic [31:0] prefix, input logic [5:0] len,
                                 input port_t port);
        logic [31:0] unused;
        wb_access(1'b1, 8'(2 * idx), prefix, unused);
        wb_access(1'b1, 8'(2 * idx + 1), {1'b1, 17'd0, len, 4'd0, port}, unused);
        model_prefix[idx] = prefix;
        model_len[idx] = len;
        model_port[idx] = port;
        model_valid[idx] = 1'b1;
    endtask

    ////////////////////
    // monitor

    // reads pre-edge values, so inputs and outputs match what the DUT sampled
    always @(posedge clk) begin : monitor
        fwd_result_t exp_res;
        int          stamp;
        cycle = cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, traffic stopped moving", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            if (rand_ready) begin
                rng_state = xorshift32(rng_state);
                out_ready <= rng_state[7];
            end else begin
                out_ready <= 1'b1;
            end
            if (!reset) begin
                if (wb_rsp.ack) ack_count = ack_count + 1;
                // in_ready low only while a result waits
                if (in_ready !== ~(out_valid & ~out_ready)) begin
                    mon_value_errors++;
                    $display("FAIL in_ready: got %h expected %h", in_ready,
                             ~(out_valid & ~out_ready));
                end
                if (in_valid && in_ready) begin
                    exp_q.push_back(expect_result(in_hdr));
                    stamp_q.push_back(cycle);
                end
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        mon_other_errors++;
                        $display("result delivered with no header pending");
                    end else begin
                        exp_res = exp_q.pop_front();
                        stamp = stamp_q.pop_front();
                        last_verdict = out_result.verdict;
                        if (out_result.verdict !== exp_res.verdict) begin
                            mon_value_errors++;
                            $display("FAIL out_result.verdict: got %h expected %h",
                                     out_result.verdict, exp_res.verdict);
                        end
                        if (out_result.port !== exp_res.port) begin
                            mon_value_errors++;
                            $display("FAIL out_result.port: got %h expected %h",
                                     out_result.port, exp_res.port);
                        end
                        if (out_result.hdr !== exp_res.hdr) begin
                            mon_value_errors++;
                            $display("FAIL out_result.hdr: got %h expected %h",
                                     out_result.hdr, exp_res.hdr);
                        end
                        if (check_latency && (cycle - stamp) != 3) begin
                            mon_value_errors++;
                            $display("FAIL out_valid latency: got %h expected %h",
                                     cycle - stamp, 3);
                        end
                    end
                end
            end
        end
    end

    ////////////////////
    // test sequence

    initial begin : stimulus
        ipv4_hdr_t   hdr;
        fwd_result_t model_res;
        reset <= 1'b1;
        in_valid <= 1'b0;
        in_hdr <= '0;
        wb_req <= '0;
        for (int i = 0; i < ROUTE_ENTRIES; i++) begin
            model_valid[i] = 1'b0;
            model_prefix[i] = 32'd0;
            model_len[i] = 6'd0;
            model_port[i] = 4'd0;
        end

        // dst, ttl, corruption, verdict, port
        vectors[0]  = '{32'h0a01_0221, 8'd64,  CORR_NONE, verdict_forward, 4'd3};
        vectors[1]  = '{32'h0a09_0909, 8'd64,  CORR_NONE, verdict_forward, 4'd3};
        vectors[2]  = '{32'hc0a8_0501, 8'd2,   CORR_NONE, verdict_forward, 4'd7};
        vectors[3]  = '{32'hac14_0101, 8'd128, CORR_NONE, verdict_forward, 4'd9};
        vectors[4]  = '{32'h0a01_0221, 8'd64,  CORR_VERSION, verdict_bad_header, 4'd0};
        vectors[5]  = '{32'h0a01_0221, 8'd64,  CORR_IHL, verdict_bad_header, 4'd0};
        vectors[6]  = '{32'hc0a8_0501, 8'd64,  CORR_CSUM, verdict_bad_checksum, 4'd0};
        vectors[7]  = '{32'hc0a8_0501, 8'd64,  CORR_TTL, verdict_ttl_expired, 4'd0};
        vectors[8]  = '{32'hc0a8_0501, 8'd0,   CORR_NONE, verdict_ttl_expired, 4'd0};
        vectors[9]  = '{32'h0808_0808, 8'd64,  CORR_NONE, verdict_no_route, 4'd0};
        vectors[10] = '{32'h0a01_0221, 8'd64,  CORR_IHL | CORR_CSUM, verdict_bad_header, 4'd0};

        // reset, first edge still unknown
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i > 0 && (out_valid !== 1'b0 || wb_rsp.ack !== 1'b0)) begin
                stim_other_errors++;
                $display("out_valid or ack not low during reset, cycle %0d", i);
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        if (out_valid !== 1'b0 || wb_rsp.ack !== 1'b0) begin
            stim_other_errors++;
            $display("out_valid or ack not low right after reset");
        end

        // empty table gives no route
        send_header(build_header(vectors[0], 100));
        wait_drain();
        if (last_verdict !== verdict_no_route) begin
            stim_value_errors++;
            $display("FAIL out_result.verdict: got %h expected %h", last_verdict,
                     verdict_no_route);
        end

        // /8 ahead of the /24 it covers, so index order decides
        program_route(0, 32'h0a00_0000, 6'd8, 4'd3);
        program_route(1, 32'h0a01_0200, 6'd24, 4'd5);
        program_route(2, 32'hc0a8_0000, 6'd16, 4'd7);
        program_route(3, 32'hac10_0000, 6'd12, 4'd9);
        for (int i = 0; i < ROUTE_ENTRIES; i++) begin
            read_check(8'(2 * i), model_prefix[i]);
            read_check(8'(2 * i + 1), {1'b1, 17'd0, model_len[i], 4'd0, model_port[i]});
        end
        read_check(8'(2 * ROUTE_ENTRIES), 32'd0);

        // vector table, back to back under random out_ready
        for (int i = 0; i < NUM_VECTORS; i++) begin
            hdr = build_header(vectors[i], i);
            model_res = expect_result(hdr);
            if (model_res.verdict !== vectors[i].verdict || model_res.port !== vectors[i].port) begin
                stim_value_errors++;
                $display("FAIL vector %0d verdict and port: got %h %h expected %h %h", i,
                         model_res.verdict, model_res.port, vectors[i].verdict, vectors[i].port);
            end
            send_header(hdr);
        end
        wait_drain();

        // single header with the output always ready
        rand_ready = 1'b0;
        repeat (2) @(posedge clk);
        check_latency = 1'b1;
        send_header(build_header(vectors[2], 200));
        wait_drain();
        check_latency = 1'b0;
        repeat (4) @(posedge clk);

        if (ack_count != access_count) begin
            stim_other_errors++;
            $display("saw %0d wishbone acks for %0d accesses", ack_count, access_count);
        end

        $display("errors: %0d value mismatches, %0d other failures",
                 stim_value_errors + mon_value_errors, stim_other_errors + mon_other_errors);
        if (stim_value_errors + mon_value_errors + stim_other_errors + mon_other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- hw/ipv4_fwd_execute.sv
// execute stage: checksum verify, ttl test, route query and verdict
module ipv4_fwd_execute
    import ipv4_fwd_pkg::*;
#(
    parameter int ROUTE_ENTRIES = 4
) (
    input  var logic        clk,
    input  var logic        reset,

    // from decode
    input  var logic        dec_valid,
    input  var dec_stage_t  dec_in,
    input  var logic        stall,

    // route table lookup, answered in the same cycle
    output var logic [31:0] lookup_addr,
    input  var logic        lookup_hit,
    input  var port_t       lookup_port,

    // stage register
    output var logic        exe_valid,
    output var exe_stage_t  exe_out
);

    logic [159:0] hdr_bits;
    logic [19:0]  sum_acc;
    logic [16:0]  sum_fold1;
    logic [15:0]  sum_fold;
    logic         csum_ok;
    fwd_verdict_e verdict;

    // table size sanity
    if (ROUTE_ENTRIES < 1 || ROUTE_ENTRIES > 32) begin : g_bad_entries
        $error("ROUTE_ENTRIES must be in 1..32");
    end

    assign lookup_addr = dec_in.hdr.dst_addr;
    assign hdr_bits    = dec_in.hdr;

    ////////////////////
    // checksum verify

    // ten halfwords, 20 bits is enough headroom
    always_comb begin
        sum_acc = '0;
        for (int i = 0; i < 10; i++) begin
            sum_acc = sum_acc + {4'b0, hdr_bits[i*16 +: 16]};
        end
    end

    // end-around carry, two folds cover the worst case
    assign sum_fold1 = {1'b0, sum_acc[15:0]} + {13'b0, sum_acc[19:16]};
    assign sum_fold  = sum_fold1[15:0] + {15'b0, sum_fold1[16]};
    assign csum_ok   = (sum_fold == 16'hffff);

    ////////////////////
    // verdict

    // first failing check wins
    always_comb begin
        if (!dec_in.hdr_ok) begin
            verdict = verdict_bad_header;
        end else if (!csum_ok) begin
            verdict = verdict_bad_checksum;
        end else if (dec_in.hdr.ttl <= 8'd1) begin
            verdict = verdict_ttl_expired;
        end else if (!lookup_hit) begin
            verdict = verdict_no_route;
        end else begin
            verdict = verdict_forward;
        end
    end

    ////////////////////
    // stage register

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (!stall) begin
            exe_valid <= dec_valid;
        end
    end

    // port kept raw, result stage zeroes it for drops
    always_ff @(posedge clk) begin
        if (!stall) begin
            exe_out.hdr     <= dec_in.hdr;
            exe_out.verdict <= verdict;
            exe_out.port    <= lookup_port;
        end
    end

endmodule

//--- hw/ipv4_fwd_pkg.sv
// shared types for the ipv4 forwarding stage
// header, stage records, verdict and wishbone access kinds, wishbone bus structs
package ipv4_fwd_pkg;

    ////////////////////
    // constants

    // wishbone word address width
    localparam int WB_ADDR_BITS = 8;

    ////////////////////
    // header and ports

    typedef logic [3:0] port_t;

    // fixed 20-byte header, no options
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_checksum;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ipv4_hdr_t;

    // drop reasons, listed in check priority after forward
    typedef enum logic [2:0] {
        verdict_forward,
        verdict_bad_header,
        verdict_bad_checksum,
        verdict_ttl_expired,
        verdict_no_route
    } fwd_verdict_e;

    ////////////////////
    // pipeline records

    // decode output
    typedef struct packed {
        ipv4_hdr_t hdr;
        logic      hdr_ok;
    } dec_stage_t;

    // execute output
    typedef struct packed {
        ipv4_hdr_t    hdr;
        fwd_verdict_e verdict;
        port_t        port;
    } exe_stage_t;

    // what leaves the pipe
    typedef struct packed {
        ipv4_hdr_t    hdr;
        fwd_verdict_e verdict;
        port_t        port;
    } fwd_result_t;

    // one route table slot
    typedef struct packed {
        logic        valid;
        logic [5:0]  prefix_len;
        port_t       port;
        logic [31:0] prefix;
    } route_entry_t;

    ////////////////////
    // wishbone classic

    typedef enum logic [1:0] {
        wb_access_none,
        wb_access_read,
        wb_access_write
    } wb_access_e;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [WB_ADDR_BITS-1:0] adr;
        logic [31:0]             dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

endpackage

//--- hw/ipv4_fwd_result.sv
// result stage: ttl decrement, incremental checksum update, output register and stall
module ipv4_fwd_result
    import ipv4_fwd_pkg::*;
(
    input  var logic        clk,
    input  var logic        reset,

    // from execute
    input  var logic        exe_valid,
    input  var exe_stage_t  exe_in,

    // result stream out
    output var logic        stall,
    output var logic        out_valid,
    input  var logic        out_ready,
    output var fwd_result_t out_result
);

    logic        res_valid;
    logic [7:0]  ttl_dec;
    logic [15:0] old_hw;
    logic [15:0] new_hw;
    logic [15:0] csum_inv;
    logic [15:0] old_hw_inv;
    logic [17:0] upd_sum;
    logic [16:0] upd_fold1;
    logic [15:0] upd_fold;
    fwd_result_t nxt_result;

    // the one stall for the whole pipe
    assign stall     = res_valid && !out_ready;
    assign out_valid = res_valid;

    ////////////////////
    // checksum update

    // ttl shares its halfword with protocol
    assign ttl_dec    = exe_in.hdr.ttl - 8'd1;
    assign old_hw     = {exe_in.hdr.ttl, exe_in.hdr.protocol};
    assign new_hw     = {ttl_dec, exe_in.hdr.protocol};
    assign csum_inv   = ~exe_in.hdr.hdr_checksum;
    assign old_hw_inv = ~old_hw;

    // ~hc + ~m + m', folded back to 16 bits
    assign upd_sum   = {2'b0, csum_inv} + {2'b0, old_hw_inv} + {2'b0, new_hw};
    assign upd_fold1 = {1'b0, upd_sum[15:0]} + {15'b0, upd_sum[17:16]};
    assign upd_fold  = upd_fold1[15:0] + {15'b0, upd_fold1[16]};

    always_comb begin
        // drops leave untouched, port zero
        nxt_result.hdr     = exe_in.hdr;
        nxt_result.verdict = exe_in.verdict;
        nxt_result.port    = '0;
        if (exe_in.verdict == verdict_forward) begin
            nxt_result.hdr.ttl          = ttl_dec;
            nxt_result.hdr.hdr_checksum = ~upd_fold;
            nxt_result.port             = exe_in.port;
        end
    end

    ////////////////////
    // output register

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (!stall) begin
            res_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_result <= nxt_result;
        end
    end

    // stream rule, result held until taken
    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_result))
    );

    // execute only forwards ttl above one
    a_fwd_ttl: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && out_result.verdict == verdict_forward) |-> (out_result.hdr.ttl != 8'd0)
    );

endmodule

//--- hw/ipv4_fwd_top.sv
// top of the ipv4 forwarding stage
// three pipeline stages and the route table
module ipv4_fwd_top
    import ipv4_fwd_pkg::*;
#(
    parameter int ROUTE_ENTRIES = 4
) (
    input  var logic        clk,
    input  var logic        reset,

    // header stream
    input  var logic        in_valid,
    output var logic        in_ready,
    input  var ipv4_hdr_t   in_hdr,

    // result stream
    output var logic        out_valid,
    input  var logic        out_ready,
    output var fwd_result_t out_result,

    // route table access
    input  var wb_req_t     wb_req,
    output var wb_rsp_t     wb_rsp
);

    // shared hold, driven by the result stage
    logic        stall;

    // stage registers
    logic        dec_valid;
    dec_stage_t  dec_q;
    logic        exe_valid;
    exe_stage_t  exe_q;

    // execute to table
    logic [31:0] lookup_addr;
    logic        lookup_hit;
    port_t       lookup_port;

    ////////////////////
    // pipeline

    ipv4_hdr_decode ipv4_hdr_decode_inst (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .in_valid  ( in_valid  ),
        .in_hdr    ( in_hdr    ),
        .stall     ( stall     ),
        .in_ready  ( in_ready  ),
        .dec_valid ( dec_valid ),
        .dec_out   ( dec_q     )
    );

    ipv4_fwd_execute #(
        .ROUTE_ENTRIES ( ROUTE_ENTRIES )
    ) ipv4_fwd_execute_inst (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .dec_valid   ( dec_valid   ),
        .dec_in      ( dec_q       ),
        .stall       ( stall       ),
        .lookup_hit  ( lookup_hit  ),
        .lookup_port ( lookup_port ),
        .lookup_addr ( lookup_addr ),
        .exe_valid   ( exe_valid   ),
        .exe_out     ( exe_q       )
    );

    ipv4_fwd_result ipv4_fwd_result_inst (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .exe_valid  ( exe_valid  ),
        .exe_in     ( exe_q      ),
        .out_ready  ( out_ready  ),
        .stall      ( stall      ),
        .out_valid  ( out_valid  ),
        .out_result ( out_result )
    );

    ////////////////////
    // route table

    ipv4_route_table #(
        .ROUTE_ENTRIES ( ROUTE_ENTRIES )
    ) ipv4_route_table_inst (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .wb_req      ( wb_req      ),
        .lookup_addr ( lookup_addr ),
        .wb_rsp      ( wb_rsp      ),
        .lookup_hit  ( lookup_hit  ),
        .lookup_port ( lookup_port )
    );

endmodule

//--- hw/ipv4_hdr_decode.sv
// decode stage: header register plus version and ihl check
module ipv4_hdr_decode
    import ipv4_fwd_pkg::*;
(
    input  var logic       clk,
    input  var logic       reset,

    // header stream in
    input  var logic       in_valid,
    output var logic       in_ready,
    input  var ipv4_hdr_t  in_hdr,

    // pipe control and stage register
    input  var logic       stall,
    output var logic       dec_valid,
    output var dec_stage_t dec_out
);

    logic hdr_ok;

    ////////////////////
    // header check

    // only plain ipv4 with no options goes on as good
    assign hdr_ok = (in_hdr.version == 4'd4) && (in_hdr.ihl == 4'd5);

    // accept whenever the pipe moves
    assign in_ready = ~stall;

    ////////////////////
    // stage register

    // valid bit, cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= in_valid;
        end
    end

    // payload, loaded on every advance
    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_out.hdr    <= in_hdr;
            dec_out.hdr_ok <= hdr_ok;
        end
    end

    ////////////////////
    // checks

    // held stage keeps both its contents and its valid bit
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        (stall && dec_valid) |=> (dec_valid && $stable(dec_out))
    );

endmodule

//--- hw/ipv4_route_table.sv
// route table: entry registers behind a wishbone classic slave
// plus a first-match prefix lookup
module ipv4_route_table
    import ipv4_fwd_pkg::*;
#(
    parameter int ROUTE_ENTRIES = 4
) (
    input  var logic        clk,
    input  var logic        reset,

    // wishbone classic slave
    input  var wb_req_t     wb_req,
    output var wb_rsp_t     wb_rsp,

    // combinational lookup
    input  var logic [31:0] lookup_addr,
    output var logic        lookup_hit,
    output var port_t       lookup_port
);

    localparam int IDX_BITS = (ROUTE_ENTRIES > 1) ? $clog2(ROUTE_ENTRIES) : 1;

    // entry storage, only valid has a reset
    logic [ROUTE_ENTRIES-1:0] valid_q;
    logic [31:0]              prefix_q     [ROUTE_ENTRIES];
    logic [5:0]               prefix_len_q [ROUTE_ENTRIES];
    port_t                    port_q       [ROUTE_ENTRIES];
    route_entry_t             entry        [ROUTE_ENTRIES];

    wb_access_e                access;
    logic                      req_seen;
    logic                      req_seen_q;
    logic                      ack_q;
    logic [WB_ADDR_BITS-2:0]   word_idx;
    logic                      word_sel;
    logic                      in_range;
    logic [IDX_BITS-1:0]       sel_idx;
    logic [31:0]               rd_word;

    // assembled view of each slot
    always_comb begin
        for (int i = 0; i < ROUTE_ENTRIES; i++) begin
            entry[i].valid      = valid_q[i];
            entry[i].prefix_len = prefix_len_q[i];
            entry[i].port       = port_q[i];
            entry[i].prefix     = prefix_q[i];
        end
    end

    ////////////////////
    // wishbone slave

    assign access = !(wb_req.cyc && wb_req.stb) ? wb_access_none :
                    wb_req.we ? wb_access_write : wb_access_read;
    assign req_seen = (access != wb_access_none);

    // word 2i prefix, word 2i+1 control
    assign word_idx = wb_req.adr[WB_ADDR_BITS-1:1];
    assign word_sel = wb_req.adr[0];
    assign in_range = int'(word_idx) < ROUTE_ENTRIES;
    assign sel_idx  = word_idx[IDX_BITS-1:0];

    // one ack per strobe, then wait for stb to drop
    always_ff @(posedge clk) begin
        if (reset) begin
            req_seen_q <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            req_seen_q <= req_seen;
            ack_q      <= req_seen && !req_seen_q;
        end
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (ack_q && access == wb_access_write && in_range && word_sel) begin
            valid_q[sel_idx] <= wb_req.dat_w[31];
        end
    end

    // entry payload, written at the ack edge
    always_ff @(posedge clk) begin
        if (ack_q && access == wb_access_write && in_range) begin
            if (!word_sel) begin
                prefix_q[sel_idx] <= wb_req.dat_w;
            end else begin
                prefix_len_q[sel_idx] <= wb_req.dat_w[13:8];
                port_q[sel_idx]       <= wb_req.dat_w[3:0];
            end
        end
    end

    // read mux, zero past the table
    always_comb begin
        rd_word = '0;
        if (in_range) begin
            if (!word_sel) begin
                rd_word = entry[sel_idx].prefix;
            end else begin
                rd_word = {entry[sel_idx].valid, 17'b0, entry[sel_idx].prefix_len,
                           4'b0, entry[sel_idx].port};
            end
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = rd_word;

    ////////////////////
    // lookup

    // walk downward so the lowest index match is left standing
    always_comb begin
        lookup_hit  = 1'b0;
        lookup_port = '0;
        for (int i = ROUTE_ENTRIES - 1; i >= 0; i--) begin
            // mask of the top prefix_len bits, /0 matches all
            if (entry[i].valid &&
                (((lookup_addr ^ entry[i].prefix) & ~(32'hffff_ffff >> entry[i].prefix_len))
                 == 32'd0)) begin
                lookup_hit  = 1'b1;
                lookup_port = entry[i].port;
            end
        end
    end

    // no ack without a sampled strobe
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (reset)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
    );

endmodule

//--- project.f
+incdir+dv
hw/ipv4_fwd_pkg.sv
hw/ipv4_hdr_decode.sv
hw/ipv4_fwd_execute.sv
hw/ipv4_fwd_result.sv
hw/ipv4_route_table.sv
hw/ipv4_fwd_top.sv
dv/ipv4_fwd_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ipv4 forwarding testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module ipv4_fwd_tb \
    -Mdir obj_dir -o ipv4_fwd_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ipv4_fwd_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
